// File: filelist.f
verilog/fill_pkg.sv
verilog/fill_arbiter.sv
verilog/rmiss_handler.sv
verilog/fill_fifo.sv
verilog/line_store.sv
verilog/fill_path_top.sv
sim/fill_path_tb.sv

// File: sim/fill_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fill_path_tb import fill_pkg::*;;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               fill_valid_i;
	logic [ADDR_W-1:0]  fill_addr_i;
	logic [DATA_W-1:0]  fill_data_i;
	wire                fill_ready_o;
	logic               miss_req_valid_i;
	logic [ADDR_W-1:0]  miss_req_addr_i;
	wire                miss_req_ready_o;
	wire                mem_req_o;
	wire [ADDR_W-1:0]   mem_addr_o;
	logic               mem_resp_valid_i;
	logic [DATA_W-1:0]  mem_resp_data_i;
	logic               store_stall_i;
	logic               lookup_valid_i;
	logic [ADDR_W-1:0]  lookup_addr_i;
	wire                lookup_done_o;
	wire                hit_o;
	wire [DATA_W-1:0]   lookup_data_o;

	logic [15:0]        lfsr_q;
	int                 errors = 0;
	int                 cycles = 0;
	logic [2:0]         mem_wait;
	logic [ADDR_W-1:0]  miss_addr_q;
	logic               exp_hit;
	logic [DATA_W-1:0]  exp_data;
	logic               shadow_valid [NUM_LINES];
	logic [TAG_W-1:0]   shadow_tag [NUM_LINES];
	logic [DATA_W-1:0]  shadow_data [NUM_LINES];
	logic [ADDR_W-1:0]  accepted [$];
	logic               ready_prev = 1'b1;
	logic               presenting = 1'b0;
	int                 present_fills = 0;
	int                 stall_fills = 0;

	fill_path_top fill_path_top_inst (.*);

	always #2 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [DATA_W-1:0] mem_line(input logic [ADDR_W-1:0] a);
		return {a ^ 16'hc3a5, ~a};
	endfunction

	function automatic void install(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		shadow_valid[a[INDEX_W-1:0]] = 1'b1;
		shadow_tag[a[INDEX_W-1:0]]   = a[ADDR_W-1:INDEX_W];
		shadow_data[a[INDEX_W-1:0]]  = d;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	// memory answers 1 to 4 cycles after the request
	always @(posedge clk) begin
		mem_resp_valid_i <= 1'b0;
		if (!rst_n) begin
			mem_wait <= '0;
		end else if (mem_req_o) begin
			mem_wait <= 3'd1 + 3'(rand_bits(2));
		end else if (mem_wait != 0) begin
			mem_wait <= mem_wait - 1'b1;
			if (mem_wait == 1) begin
				mem_resp_valid_i <= 1'b1;
				mem_resp_data_i  <= mem_line(mem_addr_o);
			end
		end
	end

	// grants are observed mid-cycle, in grant order
	always @(negedge clk) begin
		if (rst_n) begin
			if (fill_ready_o) begin
				install(fill_addr_i, fill_data_i);
				accepted.push_back(fill_addr_i);
			end
			if (miss_req_ready_o && !ready_prev) begin
				install(miss_addr_q, mem_line(miss_addr_q)); // miss line taken last cycle
			end
			ready_prev = miss_req_ready_o;
			if (miss_req_ready_o) begin
				presenting = 1'b0;
			end
			if (mem_resp_valid_i) begin
				presenting    = 1'b1;
				present_fills = 0;
			end else if (presenting && fill_ready_o) begin
				present_fills++;
			end
			if (!store_stall_i) begin
				stall_fills = 0;
			end else if (fill_ready_o) begin
				stall_fills++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin // twice the expected run
			$display("Timeout: the run did not finish within 4000 cycles");
			$display("Checks failed");
			$finish;
		end
	end

	a_reset_values: assert property (@(posedge clk) $rose(rst_n) |->
		!fill_ready_o && !mem_req_o && !lookup_done_o && miss_req_ready_o)
		else report_error("outputs wrong after reset");

	a_mem_req: assert property (@(posedge clk) disable iff (!rst_n)
		miss_req_valid_i && miss_req_ready_o |=>
			mem_req_o && mem_addr_o == $past(miss_req_addr_i))
		else report_error("memory request missing or wrong address");

	a_miss_return: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp_valid_i |-> ##[1:8] miss_req_ready_o)
		else report_error("handler did not return to idle");

	a_lookup_done: assert property (@(posedge clk) disable iff (!rst_n)
		lookup_valid_i |=> lookup_done_o)
		else report_error("lookup_done_o missing");

	a_lookup_result: assert property (@(posedge clk) disable iff (!rst_n)
		lookup_done_o |-> hit_o == exp_hit && (!exp_hit || lookup_data_o == exp_data))
		else report_error($sformatf("lookup hit %0b data %h, expected %0b %h",
			hit_o, lookup_data_o, exp_hit, exp_data));

	a_alternation: assert property (@(posedge clk) disable iff (!rst_n)
		present_fills <= 1)
		else report_error("fill granted twice while a miss line waited");

	a_stall_limit: assert property (@(posedge clk) disable iff (!rst_n)
		stall_fills <= FIFO_AFULL + 1)
		else report_error("too many fills accepted under stall");

	task automatic lookup(input logic [ADDR_W-1:0] addr);
		logic [INDEX_W-1:0] idx;
		idx = addr[INDEX_W-1:0];
		@(posedge clk);
		lookup_valid_i <= 1'b1;
		lookup_addr_i  <= addr;
		exp_hit        <= shadow_valid[idx] && shadow_tag[idx] == addr[ADDR_W-1:INDEX_W];
		exp_data       <= shadow_data[idx];
		@(posedge clk);
		lookup_valid_i <= 1'b0;
		@(posedge clk);
	endtask

	// hold fill_valid_i and present the next item after each grant
	task automatic drive_fills(input int n, input int stall_cycles);
		int                taken;
		int                cyc;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		taken = 0;
		cyc   = 0;
		@(negedge clk);
		a = rand_bits(ADDR_W);
		d = rand_bits(DATA_W);
		@(posedge clk);
		store_stall_i <= (stall_cycles > 0);
		fill_valid_i  <= 1'b1;
		fill_addr_i   <= a;
		fill_data_i   <= d;
		while (taken < n) begin
			@(negedge clk);
			cyc++;
			if (fill_ready_o) begin
				taken++;
				a = rand_bits(ADDR_W);
				d = rand_bits(DATA_W);
			end
			@(posedge clk);
			if (cyc == stall_cycles) begin
				store_stall_i <= 1'b0;
			end
			fill_valid_i <= (taken < n);
			fill_addr_i  <= a;
			fill_data_i  <= d;
		end
		store_stall_i <= 1'b0;
	endtask

	task automatic issue_miss();
		logic [ADDR_W-1:0] a;
		@(negedge clk);
		while (!miss_req_ready_o) begin
			@(negedge clk);
		end
		a = rand_bits(ADDR_W);
		@(posedge clk);
		miss_req_valid_i <= 1'b1;
		miss_req_addr_i  <= a;
		miss_addr_q      <= a;
		@(posedge clk);
		miss_req_valid_i <= 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (!miss_req_ready_o) begin
			@(negedge clk);
		end
		repeat (6) @(posedge clk); // FIFO drains in a few cycles
	endtask

	// every accepted fill, then the same index under another tag
	task automatic check_accepted();
		for (int i = 0; i < accepted.size(); i++) begin
			lookup(accepted[i]);
			lookup(accepted[i] ^ 16'h8000);
		end
		accepted.delete();
	endtask

	initial begin
		logic [ADDR_W-1:0] a;
		lfsr_q           = 16'd17104;
		rst_n            = 1'b0;
		fill_valid_i     = 1'b0;
		fill_addr_i      = '0;
		fill_data_i      = '0;
		miss_req_valid_i = 1'b0;
		miss_req_addr_i  = '0;
		mem_resp_valid_i = 1'b0;
		mem_resp_data_i  = '0;
		store_stall_i    = 1'b0;
		lookup_valid_i   = 1'b0;
		lookup_addr_i    = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			shadow_valid[i] = 1'b0;
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			a = rand_bits(ADDR_W);
			lookup(a); // store still empty
		end

		drive_fills(6, 0);
		wait_idle();
		check_accepted();

		issue_miss();
		wait_idle();
		lookup(miss_addr_q);

		// miss line competes with a held fill stream
		issue_miss();
		drive_fills(8, 0);
		wait_idle();
		lookup(miss_addr_q);
		check_accepted();

		drive_fills(8, 24);
		wait_idle();
		check_accepted();

		repeat (4) @(posedge clk);
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/fill_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fill_arbiter import fill_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,

	input  wire                fill_valid_i,
	input  wire [ADDR_W-1:0]   fill_addr_i,
	input  wire [DATA_W-1:0]   fill_data_i,
	output logic               fill_ready_o,

	input  wire                rmiss_valid_i,
	input  wire [ADDR_W-1:0]   rmiss_addr_i,
	input  wire [DATA_W-1:0]   rmiss_data_i,
	output logic               rmiss_ready_o,

	input  wire                fifo_afull_i,
	output logic               fifo_wren_o,
	output logic [ENTRY_W-1:0] fifo_wdata_o
);

	arb_state_e         state_q;
	arb_state_e         state_d;
	logic               last_rmiss_q; // miss path won last grant
	logic               last_rmiss_d;
	logic [ENTRY_W-1:0] entry_q;
	logic               fill_win;
	logic               rmiss_win;

	// on a tie the source that lost last time goes first
	assign fill_win  = fill_valid_i && (!rmiss_valid_i || last_rmiss_q);
	assign rmiss_win = rmiss_valid_i && (!fill_valid_i || !last_rmiss_q);

	always_comb begin
		state_d       = state_q;
		last_rmiss_d  = last_rmiss_q;
		fill_ready_o  = 1'b0;
		rmiss_ready_o = 1'b0;
		fifo_wren_o   = 1'b0;

		case (state_q)
			ARB_IDLE: begin
				if (!fifo_afull_i) begin
					if (fill_win) begin
						fill_ready_o = 1'b1;
						last_rmiss_d = 1'b0;
						state_d      = ARB_REQ;
					end else if (rmiss_win) begin
						rmiss_ready_o = 1'b1;
						last_rmiss_d  = 1'b1;
						state_d       = ARB_REQ;
					end
				end
			end
			ARB_REQ: begin
				if (!fifo_afull_i) begin // wait for space
					fifo_wren_o = 1'b1;
					state_d     = ARB_IDLE;
				end
			end
			default: begin
				state_d = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q      <= ARB_IDLE;
			last_rmiss_q <= 1'b0;
		end else begin
			state_q      <= state_d;
			last_rmiss_q <= last_rmiss_d;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_ready_o) begin
			entry_q <= {fill_addr_i, fill_data_i};
		end else if (rmiss_ready_o) begin
			entry_q <= {rmiss_addr_i, rmiss_data_i};
		end
	end

	assign fifo_wdata_o = entry_q;

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(fill_ready_o && rmiss_ready_o))
		else $error("fill and read-miss granted together");

endmodule

`default_nettype wire

// File: verilog/fill_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fill_fifo import fill_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                wren_i,
	input  wire [ENTRY_W-1:0]  wdata_i,
	input  wire                rden_i,
	output logic [ENTRY_W-1:0] rdata_o,
	output logic               empty_o,
	output logic               afull_o
);

	logic [ENTRY_W-1:0]    mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr_q;
	logic [FIFO_PTR_W-1:0] rd_ptr_q;
	logic [FIFO_CNT_W-1:0] count_q;
	logic                  full;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wren_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
			end
			if (rden_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({wren_i, rden_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wren_i) begin
			mem[wr_ptr_q] <= wdata_i;
		end
	end

	assign rdata_o = mem[rd_ptr_q]; // head, no read latency
	assign empty_o = (count_q == '0);
	assign full    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
	assign afull_o = (count_q >= FIFO_CNT_W'(FIFO_AFULL));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wren_i |-> !full)
		else $error("write to full fill FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		rden_i |-> !empty_o)
		else $error("read from empty fill FIFO");

endmodule

`default_nettype wire

// File: verilog/fill_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module fill_path_top import fill_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,

	input  wire               fill_valid_i,
	input  wire [ADDR_W-1:0]  fill_addr_i,
	input  wire [DATA_W-1:0]  fill_data_i,
	output wire               fill_ready_o,

	input  wire               miss_req_valid_i,
	input  wire [ADDR_W-1:0]  miss_req_addr_i,
	output wire               miss_req_ready_o,

	output wire               mem_req_o,
	output wire [ADDR_W-1:0]  mem_addr_o,
	input  wire               mem_resp_valid_i,
	input  wire [DATA_W-1:0]  mem_resp_data_i,

	input  wire               store_stall_i,

	input  wire               lookup_valid_i,
	input  wire [ADDR_W-1:0]  lookup_addr_i,
	output wire               lookup_done_o,
	output wire               hit_o,
	output wire [DATA_W-1:0]  lookup_data_o
);

	wire               rmiss_valid;
	wire [ADDR_W-1:0]  rmiss_addr;
	wire [DATA_W-1:0]  rmiss_data;
	wire               rmiss_ready;
	wire               fifo_wren;
	wire [ENTRY_W-1:0] fifo_wdata;
	wire               fifo_afull;
	wire               fifo_rden;
	wire [ENTRY_W-1:0] fifo_rdata;
	wire               fifo_empty;

	rmiss_handler rmiss_handler_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.miss_req_valid_i (miss_req_valid_i),
		.miss_req_addr_i  (miss_req_addr_i),
		.miss_req_ready_o (miss_req_ready_o),
		.mem_req_o        (mem_req_o),
		.mem_addr_o       (mem_addr_o),
		.mem_resp_valid_i (mem_resp_valid_i),
		.mem_resp_data_i  (mem_resp_data_i),
		.rmiss_valid_o    (rmiss_valid),
		.rmiss_addr_o     (rmiss_addr),
		.rmiss_data_o     (rmiss_data),
		.rmiss_ready_i    (rmiss_ready)
	);

	fill_arbiter fill_arbiter_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.fill_valid_i  (fill_valid_i),
		.fill_addr_i   (fill_addr_i),
		.fill_data_i   (fill_data_i),
		.fill_ready_o  (fill_ready_o),
		.rmiss_valid_i (rmiss_valid),
		.rmiss_addr_i  (rmiss_addr),
		.rmiss_data_i  (rmiss_data),
		.rmiss_ready_o (rmiss_ready),
		.fifo_afull_i  (fifo_afull),
		.fifo_wren_o   (fifo_wren),
		.fifo_wdata_o  (fifo_wdata)
	);

	fill_fifo fill_fifo_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.wren_i  (fifo_wren),
		.wdata_i (fifo_wdata),
		.rden_i  (fifo_rden),
		.rdata_o (fifo_rdata),
		.empty_o (fifo_empty),
		.afull_o (fifo_afull)
	);

	line_store line_store_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.fifo_empty_i   (fifo_empty),
		.fifo_rdata_i   (fifo_rdata),
		.fifo_rden_o    (fifo_rden),
		.stall_i        (store_stall_i),
		.lookup_valid_i (lookup_valid_i),
		.lookup_addr_i  (lookup_addr_i),
		.lookup_done_o  (lookup_done_o),
		.hit_o          (hit_o),
		.lookup_data_o  (lookup_data_o)
	);

endmodule

`default_nettype wire

// File: verilog/fill_pkg.sv
`default_nettype none

package fill_pkg;

	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 32;
	localparam int ENTRY_W = ADDR_W + DATA_W; // {addr, data}

	localparam int INDEX_W   = 4;
	localparam int TAG_W     = ADDR_W - INDEX_W;
	localparam int NUM_LINES = 1 << INDEX_W;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AFULL = FIFO_DEPTH - 1; // room for one pending write
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

	typedef enum logic {
		ARB_IDLE,
		ARB_REQ
	} arb_state_e;

	typedef enum logic [1:0] {
		MISS_IDLE,
		MISS_WAIT,
		MISS_PRESENT
	} miss_state_e;

endpackage

`default_nettype wire

// File: verilog/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store import fill_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,

	input  wire               fifo_empty_i,
	input  wire [ENTRY_W-1:0] fifo_rdata_i,
	output logic              fifo_rden_o,
	input  wire               stall_i,

	input  wire               lookup_valid_i,
	input  wire [ADDR_W-1:0]  lookup_addr_i,
	output logic              lookup_done_o,
	output logic              hit_o,
	output logic [DATA_W-1:0] lookup_data_o
);

	logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
	logic [DATA_W-1:0]    data_mem [NUM_LINES];
	logic [NUM_LINES-1:0] valid_q;

	logic [ADDR_W-1:0]    wr_addr;
	logic [INDEX_W-1:0]   wr_index;
	logic [INDEX_W-1:0]   lk_index;
	logic [TAG_W-1:0]     lk_tag;
	logic                 done_q;
	logic                 hit_q;
	logic [DATA_W-1:0]    rdata_q;

	assign wr_addr  = fifo_rdata_i[ENTRY_W-1 -: ADDR_W];
	assign wr_index = wr_addr[INDEX_W-1:0];
	assign lk_index = lookup_addr_i[INDEX_W-1:0];
	assign lk_tag   = lookup_addr_i[ADDR_W-1:INDEX_W];

	// drain one entry per cycle unless held off
	assign fifo_rden_o = !fifo_empty_i && !stall_i;

	always_ff @(posedge clk) begin
		if (fifo_rden_o) begin
			tag_mem[wr_index]  <= wr_addr[ADDR_W-1:INDEX_W];
			data_mem[wr_index] <= fifo_rdata_i[DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			done_q  <= 1'b0;
		end else begin
			if (fifo_rden_o) begin
				valid_q[wr_index] <= 1'b1;
			end
			done_q <= lookup_valid_i;
		end
	end

	// lookup sees the arrays as they were before this cycle's fill
	always_ff @(posedge clk) begin
		if (lookup_valid_i) begin
			hit_q   <= valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
			rdata_q <= data_mem[lk_index];
		end
	end

	assign lookup_done_o = done_q;
	assign hit_o         = hit_q;
	assign lookup_data_o = rdata_q;

endmodule

`default_nettype wire

// File: verilog/rmiss_handler.sv
`timescale 1ns/1ps
`default_nettype none

module rmiss_handler import fill_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,

	input  wire               miss_req_valid_i,
	input  wire [ADDR_W-1:0]  miss_req_addr_i,
	output logic              miss_req_ready_o,

	output logic              mem_req_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	input  wire               mem_resp_valid_i,
	input  wire [DATA_W-1:0]  mem_resp_data_i,

	output logic              rmiss_valid_o,
	output logic [ADDR_W-1:0] rmiss_addr_o,
	output logic [DATA_W-1:0] rmiss_data_o,
	input  wire               rmiss_ready_i
);

	miss_state_e        state_q;
	logic               mem_req_q;
	logic [ADDR_W-1:0]  addr_q;
	logic [DATA_W-1:0]  data_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= MISS_IDLE;
			mem_req_q <= 1'b0;
		end else begin
			mem_req_q <= 1'b0; // single-cycle pulse
			case (state_q)
				MISS_IDLE: begin
					if (miss_req_valid_i) begin
						mem_req_q <= 1'b1;
						state_q   <= MISS_WAIT;
					end
				end
				MISS_WAIT: begin
					if (mem_resp_valid_i) begin
						state_q <= MISS_PRESENT;
					end
				end
				MISS_PRESENT: begin
					if (rmiss_ready_i) begin // taken by arbiter
						state_q <= MISS_IDLE;
					end
				end
				default: begin
					state_q <= MISS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == MISS_IDLE && miss_req_valid_i) begin
			addr_q <= miss_req_addr_i;
		end
		if (state_q == MISS_WAIT && mem_resp_valid_i) begin
			data_q <= mem_resp_data_i;
		end
	end

	assign miss_req_ready_o = (state_q == MISS_IDLE);
	assign mem_req_o        = mem_req_q;
	assign mem_addr_o       = addr_q;
	assign rmiss_valid_o    = (state_q == MISS_PRESENT);
	assign rmiss_addr_o     = addr_q;
	assign rmiss_data_o     = data_q;

	// memory may only answer the outstanding request
	a_resp_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp_valid_i |-> state_q == MISS_WAIT)
		else $error("memory response outside MISS_WAIT");

endmodule

`default_nettype wire
